// File: source/mem_unit_config.svh
`ifndef MEM_UNIT_CONFIG_SVH
`define MEM_UNIT_CONFIG_SVH

`define MEM_LANES 8 // threads per warp

`define SHMEM_WORDS 64 // scratchpad depth
`define GMEM_WORDS 256

`define GMEM_LATENCY 3 // stages in global result delay line

`define WB_QUEUE_DEPTH 4 // held global results

`endif

// File: source/mem_unit_pkg.sv
`include "mem_unit_config.svh"

package mem_unit_pkg;

	localparam int SHM_IDX_W = $clog2(`SHMEM_WORDS);
	localparam int GMEM_IDX_W = $clog2(`GMEM_WORDS);

	typedef logic [31:0] lane_data_t;
	typedef lane_data_t [`MEM_LANES-1:0] warp_data_t;

	typedef struct packed
	{
		logic [31-SHM_IDX_W:0] rsvd;
		logic [SHM_IDX_W-1:0] idx; // scratchpad word
	} shm_view_t;

	typedef struct packed
	{
		logic [31-GMEM_IDX_W:0] rsvd;
		logic [GMEM_IDX_W-1:0] idx; // global word
	} gmem_view_t;

	// one effective address, each memory picks its own view
	typedef union packed
	{
		shm_view_t shm;
		gmem_view_t gmem;
	} mem_addr_u;

	typedef mem_addr_u [`MEM_LANES-1:0] warp_addr_t;

	typedef struct packed
	{
		logic [2:0] warp_id;
		logic [1:0] scb_id;
		logic [4:0] reg_addr;
		logic [`MEM_LANES-1:0] lane_mask;
		logic is_write;
	} mem_tag_t;

endpackage

// File: source/mem_if.sv
`timescale 1ns/1ns

// request from address generation to one memory path
interface mem_req_if;
	import mem_unit_pkg::*;

	logic valid;
	logic is_shared;
	mem_tag_t tag;
	warp_addr_t addr;
	warp_data_t wdata; // store data per lane

	modport source
	(
		output valid,
		output is_shared,
		output tag,
		output addr,
		output wdata
	);

	modport sink
	(
		input valid,
		input is_shared,
		input tag,
		input addr,
		input wdata
	);
endinterface

// result from one memory path to writeback
interface mem_rsp_if;
	import mem_unit_pkg::*;

	logic valid;
	mem_tag_t tag;
	warp_data_t rdata;

	modport source
	(
		output valid,
		output tag,
		output rdata
	);

	modport sink
	(
		input valid,
		input tag,
		input rdata
	);
endinterface

// File: source/mem_addr_gen.sv
`timescale 1ns/1ns
`include "mem_unit_config.svh"

module mem_addr_gen
(
	input logic clk,
	input logic rst,
	input logic instr_valid_i,
	input logic mem_read_i,
	input logic mem_write_i,
	input logic shared_i,
	input logic [`MEM_LANES-1:0] lane_mask_i,
	input logic [2:0] warp_id_i,
	input logic [1:0] scb_id_i,
	input mem_unit_pkg::warp_data_t rs_data_i,
	input mem_unit_pkg::warp_data_t rt_data_i,
	input logic [15:0] offset_i,
	input logic [4:0] reg_addr_i,
	mem_req_if.source shm_req_o,
	mem_req_if.source gmem_req_o
);
	import mem_unit_pkg::*;

	logic accept;
	logic valid_q;
	logic shared_q;
	mem_tag_t tag_q;
	warp_addr_t addr_d;
	warp_addr_t addr_q;
	warp_data_t wdata_q;

	assign accept = instr_valid_i && (mem_read_i || mem_write_i); // no-op strobes dropped

	always_comb
	begin
		for (int i = 0; i < `MEM_LANES; i++)
			addr_d[i] = rs_data_i[i] + {{16{offset_i[15]}}, offset_i};
	end

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
			valid_q <= 1'b0;
		else
			valid_q <= accept;
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			shared_q <= shared_i;
			tag_q <= '{warp_id_i, scb_id_i, reg_addr_i, lane_mask_i, mem_write_i};
			addr_q <= addr_d;
			wdata_q <= rt_data_i;
		end
	end

	assign shm_req_o.valid = valid_q && shared_q;
	assign shm_req_o.is_shared = shared_q;
	assign shm_req_o.tag = tag_q;
	assign shm_req_o.addr = addr_q;
	assign shm_req_o.wdata = wdata_q;

	assign gmem_req_o.valid = valid_q && !shared_q;
	assign gmem_req_o.is_shared = shared_q;
	assign gmem_req_o.tag = tag_q;
	assign gmem_req_o.addr = addr_q;
	assign gmem_req_o.wdata = wdata_q;

	a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst)
		instr_valid_i |-> !(mem_read_i && mem_write_i));

endmodule

// File: source/shared_mem_bank.sv
`timescale 1ns/1ns
`include "mem_unit_config.svh"

module shared_mem_bank
(
	input logic clk,
	input logic rst,
	mem_req_if.sink req_i,
	mem_rsp_if.source rsp_o
);
	import mem_unit_pkg::*;

	lane_data_t mem [0:`SHMEM_WORDS-1];
	logic acc;
	warp_data_t rd_data;

	assign acc = req_i.valid && req_i.is_shared;

	always_comb
	begin
		for (int i = 0; i < `MEM_LANES; i++)
		begin
			if (req_i.tag.lane_mask[i])
				rd_data[i] = mem[req_i.addr[i].shm.idx];
			else
				rd_data[i] = '0; // inactive lane
		end
	end

	// later lanes overwrite earlier ones on the same word
	always_ff @(posedge clk)
	begin
		if (acc && req_i.tag.is_write)
		begin
			for (int i = 0; i < `MEM_LANES; i++)
			begin
				if (req_i.tag.lane_mask[i])
					mem[req_i.addr[i].shm.idx] <= req_i.wdata[i];
			end
		end
	end

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
			rsp_o.valid <= 1'b0;
		else
			rsp_o.valid <= acc;
	end

	always_ff @(posedge clk)
	begin
		if (acc)
		begin
			rsp_o.tag <= req_i.tag;
			rsp_o.rdata <= rd_data;
		end
	end

endmodule

// File: source/global_mem_path.sv
`timescale 1ns/1ns
`include "mem_unit_config.svh"

module global_mem_path
(
	input logic clk,
	input logic rst,
	mem_req_if.sink req_i,
	mem_rsp_if.source rsp_o
);
	import mem_unit_pkg::*;

	localparam int LAT = `GMEM_LATENCY;

	lane_data_t mem [0:`GMEM_WORDS-1];
	logic acc;
	warp_data_t rd_data;
	logic [LAT-1:0] dl_valid;
	mem_tag_t dl_tag [LAT];
	warp_data_t dl_data [LAT];

	assign acc = req_i.valid && !req_i.is_shared;

	always_comb
	begin
		for (int i = 0; i < `MEM_LANES; i++)
		begin
			if (req_i.tag.lane_mask[i])
				rd_data[i] = mem[req_i.addr[i].gmem.idx];
			else
				rd_data[i] = '0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (acc && req_i.tag.is_write)
		begin
			for (int i = 0; i < `MEM_LANES; i++)
			begin
				if (req_i.tag.lane_mask[i])
					mem[req_i.addr[i].gmem.idx] <= req_i.wdata[i]; // highest lane wins
			end
		end
	end

	// fixed latency, several accesses may be in flight
	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
			dl_valid <= '0;
		else
			dl_valid <= {dl_valid[LAT-2:0], acc};
	end

	always_ff @(posedge clk)
	begin
		dl_tag[0] <= req_i.tag;
		dl_data[0] <= rd_data;
		for (int s = 1; s < LAT; s++)
		begin
			dl_tag[s] <= dl_tag[s-1];
			dl_data[s] <= dl_data[s-1];
		end
	end

	assign rsp_o.valid = dl_valid[LAT-1];
	assign rsp_o.tag = dl_tag[LAT-1];
	assign rsp_o.rdata = dl_data[LAT-1];

endmodule

// File: source/mem_writeback.sv
`timescale 1ns/1ns
`include "mem_unit_config.svh"

module mem_writeback
(
	input logic clk,
	input logic rst,
	mem_rsp_if.sink shm_rsp_i,
	mem_rsp_if.sink gmem_rsp_i,
	output logic cdb_write_o,
	output logic [4:0] cdb_reg_addr_o,
	output logic [`MEM_LANES-1:0] cdb_mask_o,
	output mem_unit_pkg::warp_data_t cdb_data_o,
	output logic fb_valid_o,
	output logic [2:0] fb_warp_id_o,
	output logic [1:0] fb_scb_id_o,
	output logic [`MEM_LANES-1:0] fb_mask_o
);
	import mem_unit_pkg::*;

	localparam int DEPTH = `WB_QUEUE_DEPTH;
	localparam int QW = $clog2(DEPTH);
	localparam int CW = $clog2(DEPTH + 1);

	mem_tag_t q_tag [DEPTH];
	warp_data_t q_data [DEPTH];
	logic [QW-1:0] wr_ptr;
	logic [QW-1:0] rd_ptr;
	logic [CW-1:0] q_count;
	logic q_empty;
	logic push;
	logic pop;
	logic sel_valid;
	mem_tag_t sel_tag;
	warp_data_t sel_data;

	assign q_empty = (q_count == '0);
	assign push = gmem_rsp_i.valid && (shm_rsp_i.valid || !q_empty); // global must wait
	assign pop = !shm_rsp_i.valid && !q_empty;

	always_comb
	begin
		sel_valid = 1'b1;
		sel_tag = shm_rsp_i.tag; // shared first
		sel_data = shm_rsp_i.rdata;
		if (!shm_rsp_i.valid)
		begin
			if (!q_empty)
			begin
				sel_tag = q_tag[rd_ptr];
				sel_data = q_data[rd_ptr];
			end
			else
			begin
				sel_valid = gmem_rsp_i.valid;
				sel_tag = gmem_rsp_i.tag;
				sel_data = gmem_rsp_i.rdata;
			end
		end
	end

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			q_count <= '0;
			fb_valid_o <= 1'b0;
			cdb_write_o <= 1'b0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == QW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == QW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			q_count <= q_count + CW'(push) - CW'(pop);
			fb_valid_o <= sel_valid;
			cdb_write_o <= sel_valid && !sel_tag.is_write; // loads only
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			q_tag[wr_ptr] <= gmem_rsp_i.tag;
			q_data[wr_ptr] <= gmem_rsp_i.rdata;
		end
		if (sel_valid)
		begin
			cdb_reg_addr_o <= sel_tag.reg_addr;
			cdb_mask_o <= sel_tag.lane_mask;
			cdb_data_o <= sel_data;
			fb_warp_id_o <= sel_tag.warp_id;
			fb_scb_id_o <= sel_tag.scb_id;
			fb_mask_o <= sel_tag.lane_mask;
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!rst)
		(q_count == CW'(DEPTH)) |-> !(push && !pop));

endmodule

// File: source/mem_unit.sv
`timescale 1ns/1ns
`include "mem_unit_config.svh"

module mem_unit
(
	input logic clk,
	input logic rst,
	input logic instr_valid_i,
	input logic mem_read_i,
	input logic mem_write_i,
	input logic shared_i,
	input logic [`MEM_LANES-1:0] lane_mask_i,
	input logic [2:0] warp_id_i,
	input logic [1:0] scb_id_i,
	input mem_unit_pkg::warp_data_t rs_data_i,
	input mem_unit_pkg::warp_data_t rt_data_i,
	input logic [15:0] offset_i,
	input logic [4:0] reg_addr_i,
	output logic cdb_write_o,
	output logic [4:0] cdb_reg_addr_o,
	output logic [`MEM_LANES-1:0] cdb_mask_o,
	output mem_unit_pkg::warp_data_t cdb_data_o,
	output logic fb_valid_o,
	output logic [2:0] fb_warp_id_o,
	output logic [1:0] fb_scb_id_o,
	output logic [`MEM_LANES-1:0] fb_mask_o
);

	mem_req_if shm_req ();
	mem_req_if gmem_req ();
	mem_rsp_if shm_rsp ();
	mem_rsp_if gmem_rsp ();

	mem_addr_gen addr_gen0
	(
		.clk(clk),
		.rst(rst),
		.instr_valid_i(instr_valid_i),
		.mem_read_i(mem_read_i),
		.mem_write_i(mem_write_i),
		.shared_i(shared_i),
		.lane_mask_i(lane_mask_i),
		.warp_id_i(warp_id_i),
		.scb_id_i(scb_id_i),
		.rs_data_i(rs_data_i),
		.rt_data_i(rt_data_i),
		.offset_i(offset_i),
		.reg_addr_i(reg_addr_i),
		.shm_req_o(shm_req.source),
		.gmem_req_o(gmem_req.source)
	);

	shared_mem_bank shmem0
	(
		.clk(clk),
		.rst(rst),
		.req_i(shm_req.sink),
		.rsp_o(shm_rsp.source)
	);

	global_mem_path gmem0
	(
		.clk(clk),
		.rst(rst),
		.req_i(gmem_req.sink),
		.rsp_o(gmem_rsp.source)
	);

	mem_writeback wb0
	(
		.clk(clk),
		.rst(rst),
		.shm_rsp_i(shm_rsp.sink),
		.gmem_rsp_i(gmem_rsp.sink),
		.cdb_write_o(cdb_write_o),
		.cdb_reg_addr_o(cdb_reg_addr_o),
		.cdb_mask_o(cdb_mask_o),
		.cdb_data_o(cdb_data_o),
		.fb_valid_o(fb_valid_o),
		.fb_warp_id_o(fb_warp_id_o),
		.fb_scb_id_o(fb_scb_id_o),
		.fb_mask_o(fb_mask_o)
	);

endmodule

// File: testbench/tb_mem_unit.sv
`timescale 1ns/1ns
`include "mem_unit_config.svh"

module tb_mem_unit;
	import mem_unit_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 8;
	localparam int N_INSTR = 40 + 2 + 8 + 4 + 3 + 60; // fill plus tests 1 to 5

	typedef struct packed
	{
		logic [31:0] issue_cyc;
		logic [3:0] lat; // 0 means not checked
		logic is_write;
		logic [2:0] warp;
		logic [1:0] scb;
		logic [4:0] reg_addr;
		logic [`MEM_LANES-1:0] mask;
		warp_data_t data;
	} exp_t;

	logic clk = 1'b0;
	logic rst;
	logic instr_valid_i;
	logic mem_read_i;
	logic mem_write_i;
	logic shared_i;
	logic [`MEM_LANES-1:0] lane_mask_i;
	logic [2:0] warp_id_i;
	logic [1:0] scb_id_i;
	warp_data_t rs_data_i;
	warp_data_t rt_data_i;
	logic [15:0] offset_i;
	logic [4:0] reg_addr_i;
	logic cdb_write_o;
	logic [4:0] cdb_reg_addr_o;
	logic [`MEM_LANES-1:0] cdb_mask_o;
	warp_data_t cdb_data_o;
	logic fb_valid_o;
	logic [2:0] fb_warp_id_o;
	logic [1:0] fb_scb_id_o;
	logic [`MEM_LANES-1:0] fb_mask_o;

	lane_data_t shm_model [`SHMEM_WORDS];
	lane_data_t gmem_model [`GMEM_WORDS];
	exp_t shm_q [$];
	exp_t gmem_q [$];
	logic [3:0] inflight = '0; // one bit per scoreboard slot
	logic [31:0] lfsr = 32'h7ca7;
	int cycle = 0;
	int errors = 0;
	int checks = 0;
	int fb_count = 0;
	int n_issued = 0;

	mem_unit dut0
	(
		.clk(clk),
		.rst(rst),
		.instr_valid_i(instr_valid_i),
		.mem_read_i(mem_read_i),
		.mem_write_i(mem_write_i),
		.shared_i(shared_i),
		.lane_mask_i(lane_mask_i),
		.warp_id_i(warp_id_i),
		.scb_id_i(scb_id_i),
		.rs_data_i(rs_data_i),
		.rt_data_i(rt_data_i),
		.offset_i(offset_i),
		.reg_addr_i(reg_addr_i),
		.cdb_write_o(cdb_write_o),
		.cdb_reg_addr_o(cdb_reg_addr_o),
		.cdb_mask_o(cdb_mask_o),
		.cdb_data_o(cdb_data_o),
		.fb_valid_o(fb_valid_o),
		.fb_warp_id_o(fb_warp_id_o),
		.fb_scb_id_o(fb_scb_id_o),
		.fb_mask_o(fb_mask_o)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] rnd(input int nbits);
		logic [31:0] r;
		r = '0;
		for (int b = 0; b < nbits; b++)
		begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic lane_data_t fill_word(input int idx, input logic sh);
		return (32'hdead0000 ^ (idx * 32'h00010101)) ^ (sh ? 32'h80000000 : 32'h0);
	endfunction

	// applies the access to the model memories and queues the expected completion
	function automatic void model_issue(input exp_t e_in, input logic sh, input warp_data_t rs,
		input warp_data_t rt, input logic [15:0] off);
		exp_t e;
		logic [31:0] ea;
		int idx;
		e = e_in;
		e.data = '0;
		for (int i = 0; i < `MEM_LANES; i++)
		begin
			ea = rs[i] + {{16{off[15]}}, off};
			idx = sh ? int'(ea % `SHMEM_WORDS) : int'(ea % `GMEM_WORDS);
			if (e.mask[i] && e.is_write)
			begin
				if (sh)
					shm_model[idx] = rt[i]; // lane order leaves the highest lane
				else
					gmem_model[idx] = rt[i];
			end
			else if (e.mask[i])
				e.data[i] = sh ? shm_model[idx] : gmem_model[idx];
		end
		if (sh)
			shm_q.push_back(e);
		else
			gmem_q.push_back(e);
	endfunction

	task automatic report_error(input string msg);
		errors++;
		$display("FAILED %0t: %s", $time, msg);
	endtask

	task automatic check_result(input exp_t e);
		checks++;
		if (fb_warp_id_o != e.warp)
			report_error($sformatf("scb %0d warp %0d, expected %0d", e.scb, fb_warp_id_o, e.warp));
		if (fb_mask_o != e.mask)
			report_error($sformatf("scb %0d fb mask %h, expected %h", e.scb, fb_mask_o, e.mask));
		if (e.lat != 0 && (cycle - int'(e.issue_cyc)) != int'(e.lat))
			report_error($sformatf("scb %0d latency %0d, expected %0d", e.scb,
				cycle - int'(e.issue_cyc), e.lat));
		if (e.is_write && cdb_write_o)
			report_error($sformatf("store scb %0d wrote the CDB", e.scb));
		if (!e.is_write && !cdb_write_o)
			report_error($sformatf("load scb %0d gave no CDB write", e.scb));
		if (!e.is_write && cdb_write_o)
		begin
			if (cdb_reg_addr_o != e.reg_addr)
				report_error($sformatf("scb %0d reg %0d, expected %0d", e.scb,
					cdb_reg_addr_o, e.reg_addr));
			if (cdb_mask_o != e.mask)
				report_error($sformatf("scb %0d cdb mask %h, expected %h", e.scb,
					cdb_mask_o, e.mask));
			for (int i = 0; i < `MEM_LANES; i++)
			begin
				if (cdb_data_o[i] !== e.data[i])
					report_error($sformatf("scb %0d lane %0d data %h, expected %h", e.scb, i,
						cdb_data_o[i], e.data[i]));
			end
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk)
	begin : compare_outputs
		exp_t e;
		logic found;
		if (rst)
		begin
			if (cdb_write_o && !fb_valid_o)
				report_error("CDB write without feedback");
			if (fb_valid_o)
			begin
				fb_count++;
				found = 1'b0;
				if (shm_q.size() > 0 && shm_q[0].scb == fb_scb_id_o)
				begin
					e = shm_q.pop_front();
					found = 1'b1;
				end
				else if (gmem_q.size() > 0 && gmem_q[0].scb == fb_scb_id_o)
				begin
					e = gmem_q.pop_front();
					found = 1'b1;
				end
				if (!found)
					report_error($sformatf("feedback for scb %0d matches no pending head",
						fb_scb_id_o));
				else
				begin
					check_result(e);
					inflight[e.scb] = 1'b0;
				end
			end
		end
	end

	// called 1 ns after a rising edge and returns at the same phase
	task automatic issue(input logic rd, input logic wr, input logic sh,
		input logic [`MEM_LANES-1:0] mask, input warp_data_t rs, input warp_data_t rt,
		input logic [15:0] off, input logic [3:0] lat);
		exp_t e;
		int id;
		id = -1;
		while (id < 0)
		begin
			for (int k = 0; k < 4; k++)
			begin
				if (id < 0 && !inflight[k])
					id = k;
			end
			if (id < 0)
			begin
				@(posedge clk);
				#1;
			end
		end
		e = '0;
		e.issue_cyc = cycle; // cycle the strobe is presented in
		e.lat = lat;
		e.is_write = wr;
		e.warp = rnd(3);
		e.scb = id;
		e.reg_addr = rnd(5);
		e.mask = mask;
		instr_valid_i = 1'b1;
		mem_read_i = rd;
		mem_write_i = wr;
		shared_i = sh;
		lane_mask_i = mask;
		warp_id_i = e.warp;
		scb_id_i = e.scb;
		rs_data_i = rs;
		rt_data_i = rt;
		offset_i = off;
		reg_addr_i = e.reg_addr;
		if (rd || wr)
		begin
			model_issue(e, sh, rs, rt, off);
			inflight[id] = 1'b1;
			n_issued++;
		end
		@(posedge clk);
		#1;
		instr_valid_i = 1'b0;
	endtask

	task automatic drain();
		while (inflight != 4'b0)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic end_test(input string name, input int err_before);
		if (errors == err_before)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - err_before);
	endtask

	initial
	begin : run_tests
		warp_data_t rs;
		warp_data_t rt;
		logic [15:0] off;
		logic sh;
		logic wr;
		int err0;
		int fb0;
		rst = 1'b0;
		instr_valid_i = 1'b0;
		mem_read_i = 1'b0;
		mem_write_i = 1'b0;
		shared_i = 1'b0;
		lane_mask_i = '0;
		warp_id_i = '0;
		scb_id_i = '0;
		rs_data_i = '0;
		rt_data_i = '0;
		offset_i = '0;
		reg_addr_i = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b1;

		err0 = errors; // fill both memories so every load hits known data
		for (int k = 0; k < `SHMEM_WORDS / `MEM_LANES + `GMEM_WORDS / `MEM_LANES; k++)
		begin
			sh = (k < `SHMEM_WORDS / `MEM_LANES);
			for (int i = 0; i < `MEM_LANES; i++)
			begin
				rs[i] = (sh ? k : k - `SHMEM_WORDS / `MEM_LANES) * `MEM_LANES + i;
				rt[i] = fill_word(int'(rs[i]), sh);
			end
			issue(1'b0, 1'b1, sh, '1, rs, rt, 16'h0, 4'd0);
		end
		drain();
		end_test("fill", err0);

		err0 = errors;
		for (int i = 0; i < `MEM_LANES; i++)
		begin
			rs[i] = 32'h100 + 3 * i;
			rt[i] = rnd(32);
		end
		issue(1'b0, 1'b1, 1'b1, '1, rs, rt, 16'h0004, 4'd3);
		drain();
		issue(1'b1, 1'b0, 1'b1, '1, rs, rt, 16'h0004, 4'd3);
		drain();
		end_test("1 shared store and load", err0);

		err0 = errors;
		for (int n = 0; n < 4; n++)
		begin
			for (int i = 0; i < `MEM_LANES; i++)
			begin
				rs[i] = rnd(32);
				rt[i] = rnd(32);
			end
			off = 16'h8000 | rnd(15); // negative offset
			issue(1'b0, 1'b1, 1'b0, rnd(8), rs, rt, off, 4'd5);
			drain();
			issue(1'b1, 1'b0, 1'b0, rnd(8), rs, rt, off, 4'd5);
			drain();
		end
		end_test("2 global masked access", err0);

		err0 = errors;
		for (int p = 0; p < 2; p++)
		begin
			sh = (p == 0);
			rs[0] = rnd(32); // every lane on one word
			for (int i = 0; i < `MEM_LANES; i++)
			begin
				rs[i] = rs[0];
				rt[i] = rnd(32);
			end
			off = rnd(16);
			issue(1'b0, 1'b1, sh, 8'b0010_0100, rs, rt, off, sh ? 4'd3 : 4'd5);
			drain();
			issue(1'b1, 1'b0, sh, '1, rs, rt, off, sh ? 4'd3 : 4'd5);
			drain();
		end
		end_test("3 same word store", err0);

		err0 = errors;
		issue(1'b0, 1'b1, 1'b1, rnd(8), rs, rt, rnd(16), 4'd3);
		drain();
		issue(1'b0, 1'b1, 1'b0, rnd(8), rs, rt, rnd(16), 4'd5);
		drain();
		fb0 = fb_count;
		issue(1'b0, 1'b0, rnd(1), '1, rs, rt, rnd(16), 4'd0);
		repeat (12) @(posedge clk);
		#1;
		if (fb_count != fb0)
			report_error("strobe without read or write produced feedback");
		end_test("4 store feedback and no-op", err0);

		err0 = errors;
		for (int n = 0; n < 60; n++)
		begin
			sh = rnd(1);
			wr = rnd(1);
			for (int i = 0; i < `MEM_LANES; i++)
			begin
				rs[i] = rnd(32);
				rt[i] = rnd(32);
			end
			issue(!wr, wr, sh, rnd(8), rs, rt, rnd(16), 4'd0);
		end
		drain();
		if (shm_q.size() != 0 || gmem_q.size() != 0)
			report_error("instructions left without completion");
		end_test("5 random mix", err0);

		$display("%0d instructions, %0d completions checked, %0d errors",
			n_issued, checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial
	begin : watchdog
		#((N_INSTR * 20 + RESET_CYCLES) * CLK_PERIOD);
		$display("timeout: the tests did not finish in the allowed time");
		$display("** FAIL **");
		$finish;
	end

endmodule

// File: sources.f
+incdir+source
source/mem_unit_pkg.sv
source/mem_if.sv
source/mem_addr_gen.sv
source/shared_mem_bank.sv
source/global_mem_path.sv
source/mem_writeback.sv
source/mem_unit.sv
testbench/tb_mem_unit.sv
